// ==== rtl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // instruction field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 26;
    localparam int RS_HI  = 25;
    localparam int RS_LO  = 21;
    localparam int RT_HI  = 20;
    localparam int RT_LO  = 16;
    localparam int RD_HI  = 15;
    localparam int RD_LO  = 11;
    localparam int SA_HI  = 10;
    localparam int SA_LO  = 6;
    localparam int FN_HI  = 5;
    localparam int FN_LO  = 0;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;

    // function codes under SPECIAL
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam reg_addr_t NOP_REG = 5'd0;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_AND   = 8'b0010_0100,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110
    } aluop_e;

    // result class seen by the execute stage
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

`default_nettype wire

// ==== rtl/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if import decode_pkg::*; ();

    logic      re1;
    logic      re2;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     imm;
    reg_addr_t wd;
    logic      wreg;
    aluop_e    aluop;
    alusel_e   alusel;
    logic      illegal;

    modport dec (
        output re1, re2, ra1, ra2, imm, wd, wreg, aluop, alusel, illegal
    );

    // operand selects and pipeline register
    modport sink (
        input re1, re2, ra1, ra2, imm, wd, wreg, aluop, alusel, illegal
    );

endinterface

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import decode_pkg::*; (
    input  inst_t     inst_i,
    decode_if.dec     dec
);

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] shamt;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [15:0] imm16;

    aluop_e  r_op;
    alusel_e r_sel;
    logic    r_known;
    aluop_e  sh_op;
    logic    sh_imm;
    aluop_e  i_op;
    alusel_e i_sel;
    word_t   i_imm;

    assign op    = inst_i[OP_HI:OP_LO];
    assign rs    = inst_i[RS_HI:RS_LO];
    assign rt    = inst_i[RT_HI:RT_LO];
    assign rd    = inst_i[RD_HI:RD_LO];
    assign shamt = inst_i[SA_HI:SA_LO];
    assign funct = inst_i[FN_HI:FN_LO];
    assign imm16 = inst_i[IMM_HI:IMM_LO];

    // register-register ops under SPECIAL
    always_comb begin
        case (funct)
            FN_OR:   r_op = ALU_OR;
            FN_AND:  r_op = ALU_AND;
            FN_XOR:  r_op = ALU_XOR;
            FN_NOR:  r_op = ALU_NOR;
            FN_SLLV: r_op = ALU_SLL;
            FN_SRLV: r_op = ALU_SRL;
            FN_SRAV: r_op = ALU_SRA;
            FN_ADD:  r_op = ALU_ADD;
            FN_ADDU: r_op = ALU_ADDU;
            FN_SUB:  r_op = ALU_SUB;
            FN_SUBU: r_op = ALU_SUBU;
            FN_SLT:  r_op = ALU_SLT;
            FN_SLTU: r_op = ALU_SLTU;
            default: r_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (funct)
            FN_OR, FN_AND, FN_XOR, FN_NOR: r_sel = SEL_LOGIC;
            FN_SLLV, FN_SRLV, FN_SRAV:     r_sel = SEL_SHIFT;
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
            FN_SLT, FN_SLTU:               r_sel = SEL_ARITH;
            default:                       r_sel = SEL_NOP;
        endcase
    end

    assign r_known = (r_sel != SEL_NOP) && (shamt == 5'd0);

    // shift by shamt needs op and rs all zero
    always_comb begin
        case (funct)
            FN_SLL:  sh_op = ALU_SLL;
            FN_SRL:  sh_op = ALU_SRL;
            FN_SRA:  sh_op = ALU_SRA;
            default: sh_op = ALU_NOP;
        endcase
    end

    assign sh_imm = (inst_i[OP_HI:RS_LO] == 11'd0) && (sh_op != ALU_NOP);

    always_comb begin
        case (op)
            OPC_ORI, OPC_LUI: i_op = ALU_OR;
            OPC_ANDI:         i_op = ALU_AND;
            OPC_XORI:         i_op = ALU_XOR;
            OPC_ADDI:         i_op = ALU_ADDI;
            OPC_ADDIU:        i_op = ALU_ADDIU;
            OPC_SLTI:         i_op = ALU_SLT;
            OPC_SLTIU:        i_op = ALU_SLTU;
            default:          i_op = ALU_NOP;
        endcase
    end

    // immediate extension per opcode
    always_comb begin
        case (op)
            OPC_ORI, OPC_ANDI, OPC_XORI: begin
                i_sel = SEL_LOGIC;
                i_imm = {16'h0000, imm16};
            end
            OPC_LUI: begin
                i_sel = SEL_LOGIC;
                i_imm = {imm16, 16'h0000};
            end
            OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
                i_sel = SEL_ARITH;
                i_imm = {{16{imm16[15]}}, imm16};
            end
            default: begin
                i_sel = SEL_NOP;
                i_imm = '0;
            end
        endcase
    end

    assign dec.ra1 = rs;
    assign dec.ra2 = rt;

    always_comb begin
        // unknown encodings fall through with these values
        dec.aluop   = ALU_NOP;
        dec.alusel  = SEL_NOP;
        dec.wd      = NOP_REG;
        dec.wreg    = 1'b0;
        dec.re1     = 1'b0;
        dec.re2     = 1'b0;
        dec.imm     = '0;
        dec.illegal = 1'b1;
        if (sh_imm) begin
            dec.aluop   = sh_op;
            dec.alusel  = SEL_SHIFT;
            dec.wd      = rd;
            dec.wreg    = 1'b1;
            dec.re2     = 1'b1;
            dec.imm     = {27'd0, shamt};
            dec.illegal = 1'b0;
        end else if (op == OPC_SPECIAL && r_known) begin
            dec.aluop   = r_op;
            dec.alusel  = r_sel;
            dec.wd      = rd;
            dec.wreg    = 1'b1;
            dec.re1     = 1'b1;
            dec.re2     = 1'b1;
            dec.illegal = 1'b0;
        end else if (i_sel != SEL_NOP) begin
            dec.aluop   = i_op;
            dec.alusel  = i_sel;
            dec.wd      = rt;
            dec.wreg    = 1'b1;
            dec.re1     = 1'b1;
            dec.imm     = i_imm;
            dec.illegal = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_select import decode_pkg::*; (
    input  logic      port_sel_i,
    decode_if.sink    dec,
    input  word_t     rf_rdata_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    logic      re;
    reg_addr_t ra;

    // 0 picks the rs port, 1 the rt port
    assign re = port_sel_i ? dec.re2 : dec.re1;
    assign ra = port_sel_i ? dec.ra2 : dec.ra1;

    // execute result is newer than memory result
    always_comb begin
        if (!re) begin
            operand_o = dec.imm;
        end else if (ex_wreg_i && (ex_wd_i == ra)) begin
            operand_o = ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == ra)) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg import decode_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      valid_i,
    decode_if.sink    dec,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    output logic      ex_valid_o,
    output aluop_e    ex_aluop_o,
    output alusel_e   ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_illegal_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_aluop_o   <= ALU_NOP;
            ex_alusel_o  <= SEL_NOP;
            ex_reg1_o    <= '0;
            ex_reg2_o    <= '0;
            ex_wd_o      <= NOP_REG;
            ex_wreg_o    <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o <= valid_i;
            // fields hold between strobes
            if (valid_i) begin
                ex_aluop_o   <= dec.aluop;
                ex_alusel_o  <= dec.alusel;
                ex_reg1_o    <= reg1_i;
                ex_reg2_o    <= reg2_i;
                ex_wd_o      <= dec.wd;
                ex_wreg_o    <= dec.wreg;
                ex_illegal_o <= dec.illegal;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    // register file
    output logic      rf_re1_o,
    output logic      rf_re2_o,
    output reg_addr_t rf_raddr1_o,
    output reg_addr_t rf_raddr2_o,
    input  word_t     rf_rdata1_i,
    input  word_t     rf_rdata2_i,
    // bypass from execute and memory
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    // to execute
    output logic      ex_valid_o,
    output aluop_e    ex_aluop_o,
    output alusel_e   ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_illegal_o
);

    decode_if dec_if ();

    word_t reg1;
    word_t reg2;

    assign rf_re1_o    = dec_if.re1;
    assign rf_re2_o    = dec_if.re2;
    assign rf_raddr1_o = dec_if.ra1;
    assign rf_raddr2_o = dec_if.ra2;

    instr_decoder u_decoder (
        .inst_i (inst_i),
        .dec    (dec_if.dec)
    );

    operand_select op1_sel (
        .port_sel_i  (1'b0),
        .dec         (dec_if.sink),
        .rf_rdata_i  (rf_rdata1_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    operand_select op2_sel (
        .port_sel_i  (1'b1),
        .dec         (dec_if.sink),
        .rf_rdata_i  (rf_rdata2_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .valid_i      (inst_valid_i),
        .dec          (dec_if.sink),
        .reg1_i       (reg1),
        .reg2_i       (reg2),
        .ex_valid_o   (ex_valid_o),
        .ex_aluop_o   (ex_aluop_o),
        .ex_alusel_o  (ex_alusel_o),
        .ex_reg1_o    (ex_reg1_o),
        .ex_reg2_o    (ex_reg2_o),
        .ex_wd_o      (ex_wd_o),
        .ex_wreg_o    (ex_wreg_o),
        .ex_illegal_o (ex_illegal_o)
    );

endmodule

`default_nettype wire

// ==== test/decode_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_checker import decode_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    // one expected record per strobe
    input  logic      exp_push_i,
    input  aluop_e    exp_aluop_i,
    input  alusel_e   exp_alusel_i,
    input  word_t     exp_reg1_i,
    input  word_t     exp_reg2_i,
    input  reg_addr_t exp_wd_i,
    input  logic      exp_wreg_i,
    input  logic      exp_illegal_i,
    input  logic      exp_re1_i,
    input  logic      exp_re2_i,
    input  logic      final_check_i,
    // DUT outputs
    input  logic      rf_re1_i,
    input  logic      rf_re2_i,
    input  logic      ex_valid_i,
    input  aluop_e    ex_aluop_i,
    input  alusel_e   ex_alusel_i,
    input  word_t     ex_reg1_i,
    input  word_t     ex_reg2_i,
    input  reg_addr_t ex_wd_i,
    input  logic      ex_wreg_i,
    input  logic      ex_illegal_i,
    output int        value_errors_o,
    output int        seq_errors_o,
    output int        pending_o
);

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        logic      illegal;
        int        cycle;
    } expect_t;

    expect_t pending_q[$];
    expect_t rec;
    int      cycle = 0;
    int      value_errors = 0;
    int      seq_errors = 0;
    int      pending_count = 0;
    logic    final_done = 1'b0;

    assign value_errors_o = value_errors;
    assign seq_errors_o   = seq_errors;
    assign pending_o      = pending_count;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic verify_reset_values();
        compare_field("ex_valid_o", 32'd0, 32'(ex_valid_i));
        compare_field("ex_aluop_o", 32'd0, 32'(ex_aluop_i));
        compare_field("ex_alusel_o", 32'd0, 32'(ex_alusel_i));
        compare_field("ex_reg1_o", 32'd0, ex_reg1_i);
        compare_field("ex_reg2_o", 32'd0, ex_reg2_i);
        compare_field("ex_wd_o", 32'd0, 32'(ex_wd_i));
        compare_field("ex_wreg_o", 32'd0, 32'(ex_wreg_i));
        compare_field("ex_illegal_o", 32'd0, 32'(ex_illegal_i));
    endtask

    task automatic match_record(input expect_t e);
        // result must show one cycle after its strobe
        if (cycle != e.cycle + 1) begin
            $display("ex_valid_o at %0t ns came %0d cycles after its strobe",
                     $time, cycle - e.cycle);
            seq_errors++;
        end
        compare_field("ex_aluop_o", 32'(e.aluop), 32'(ex_aluop_i));
        compare_field("ex_alusel_o", 32'(e.alusel), 32'(ex_alusel_i));
        compare_field("ex_reg1_o", e.reg1, ex_reg1_i);
        compare_field("ex_reg2_o", e.reg2, ex_reg2_i);
        compare_field("ex_wd_o", 32'(e.wd), 32'(ex_wd_i));
        compare_field("ex_wreg_o", 32'(e.wreg), 32'(ex_wreg_i));
        compare_field("ex_illegal_o", 32'(e.illegal), 32'(ex_illegal_i));
    endtask

    // sample on the falling edge away from the register update
    always @(negedge clk) begin
        cycle++;
        if (!arst_n_i) begin
            verify_reset_values();
        end else begin
            if (exp_push_i) begin
                // read enables are combinational in the strobe cycle
                compare_field("rf_re1_o", 32'(exp_re1_i), 32'(rf_re1_i));
                compare_field("rf_re2_o", 32'(exp_re2_i), 32'(rf_re2_i));
                rec.aluop   = exp_aluop_i;
                rec.alusel  = exp_alusel_i;
                rec.reg1    = exp_reg1_i;
                rec.reg2    = exp_reg2_i;
                rec.wd      = exp_wd_i;
                rec.wreg    = exp_wreg_i;
                rec.illegal = exp_illegal_i;
                rec.cycle   = cycle;
                pending_q.push_back(rec);
            end
            if (ex_valid_i) begin
                if (pending_q.size() == 0) begin
                    $display("ex_valid_o high at %0t ns with no instruction outstanding", $time);
                    seq_errors++;
                end else begin
                    rec = pending_q.pop_front();
                    match_record(rec);
                end
            end
            if (final_check_i && !final_done) begin
                final_done = 1'b1;
                if (pending_q.size() != 0) begin
                    $display("%0d instructions never reached the execute outputs",
                             pending_q.size());
                    seq_errors++;
                end
            end
        end
        pending_count = pending_q.size();
    end

endmodule

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        inst_t     inst;
        logic      exw;
        reg_addr_t exd;
        word_t     exdata;
        logic      memw;
        reg_addr_t memd;
        word_t     memdata;
        int        gap;
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        logic      illegal;
        logic      re1;
        logic      re2;
    } row_t;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    logic      rf_re1, rf_re2;
    reg_addr_t rf_raddr1, rf_raddr2;
    word_t     rf_rdata1, rf_rdata2;
    logic      ex_wreg_i, mem_wreg_i;
    reg_addr_t ex_wd_i, mem_wd_i;
    word_t     ex_wdata_i, mem_wdata_i;
    logic      ex_valid, ex_wreg, ex_illegal;
    aluop_e    ex_aluop;
    alusel_e   ex_alusel;
    word_t     ex_reg1, ex_reg2;
    reg_addr_t ex_wd;

    logic      exp_push, final_check;
    row_t      cur;
    row_t      rows[$];
    row_t      bypass;
    logic      exp_re1 = 1'b0;
    logic      exp_re2 = 1'b0;
    int        total_gap = 0;
    int        watchdog_ns = 0;
    int        value_errors, seq_errors, pending;

    always #CLK_HALF clk = ~clk;

    // register n reads n in every byte
    assign rf_rdata1 = 32'(rf_raddr1) * 32'h0101_0101;
    assign rf_rdata2 = 32'(rf_raddr2) * 32'h0101_0101;

    decode_stage UUT (
        .clk (clk), .arst_n_i (arst_n_i), .inst_valid_i (inst_valid_i), .inst_i (inst_i),
        .rf_re1_o (rf_re1), .rf_re2_o (rf_re2),
        .rf_raddr1_o (rf_raddr1), .rf_raddr2_o (rf_raddr2),
        .rf_rdata1_i (rf_rdata1), .rf_rdata2_i (rf_rdata2),
        .ex_wreg_i (ex_wreg_i), .ex_wd_i (ex_wd_i), .ex_wdata_i (ex_wdata_i),
        .mem_wreg_i (mem_wreg_i), .mem_wd_i (mem_wd_i), .mem_wdata_i (mem_wdata_i),
        .ex_valid_o (ex_valid), .ex_aluop_o (ex_aluop), .ex_alusel_o (ex_alusel),
        .ex_reg1_o (ex_reg1), .ex_reg2_o (ex_reg2), .ex_wd_o (ex_wd),
        .ex_wreg_o (ex_wreg), .ex_illegal_o (ex_illegal)
    );

    decode_checker u_checker (
        .clk (clk), .arst_n_i (arst_n_i), .exp_push_i (exp_push),
        .exp_aluop_i (cur.aluop), .exp_alusel_i (cur.alusel),
        .exp_reg1_i (cur.reg1), .exp_reg2_i (cur.reg2), .exp_wd_i (cur.wd),
        .exp_wreg_i (cur.wreg), .exp_illegal_i (cur.illegal),
        .exp_re1_i (cur.re1), .exp_re2_i (cur.re2), .final_check_i (final_check),
        .rf_re1_i (rf_re1), .rf_re2_i (rf_re2),
        .ex_valid_i (ex_valid), .ex_aluop_i (ex_aluop), .ex_alusel_i (ex_alusel),
        .ex_reg1_i (ex_reg1), .ex_reg2_i (ex_reg2), .ex_wd_i (ex_wd),
        .ex_wreg_i (ex_wreg), .ex_illegal_i (ex_illegal),
        .value_errors_o (value_errors), .seq_errors_o (seq_errors), .pending_o (pending)
    );

    function automatic inst_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [5:0] fn);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic inst_t shift_type(reg_addr_t rt, reg_addr_t rd, logic [4:0] sa,
                                         logic [5:0] fn);
        return {11'd0, rt, rd, sa, fn};
    endfunction

    function automatic inst_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic set_bypass(logic exw, reg_addr_t exd, word_t exdata,
                              logic memw, reg_addr_t memd, word_t memdata);
        bypass.exw     = exw;
        bypass.exd     = exd;
        bypass.exdata  = exdata;
        bypass.memw    = memw;
        bypass.memd    = memd;
        bypass.memdata = memdata;
    endtask

    // read enables expected for the rows that follow
    task automatic set_reads(logic re1, logic re2);
        exp_re1 = re1;
        exp_re2 = re2;
    endtask

    task automatic add_row(inst_t inst, int gap, aluop_e aluop, alusel_e alusel,
                           word_t reg1, word_t reg2, reg_addr_t wd, logic wreg,
                           logic illegal);
        row_t r;
        r         = bypass;
        r.inst    = inst;
        r.gap     = gap;
        r.aluop   = aluop;
        r.alusel  = alusel;
        r.reg1    = reg1;
        r.reg2    = reg2;
        r.wd      = wd;
        r.wreg    = wreg;
        r.illegal = illegal;
        r.re1     = exp_re1;
        r.re2     = exp_re2;
        rows.push_back(r);
        total_gap += gap;
    endtask

    task automatic build_table();
        set_bypass(1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
        set_reads(1'b1, 1'b1);
        add_row(r_type(5'd1, 5'd2, 5'd3, FN_OR), 0,
                ALU_OR, SEL_LOGIC, 32'h0101_0101, 32'h0202_0202, 5'd3, 1'b1, 1'b0);
        add_row(r_type(5'd4, 5'd5, 5'd6, FN_NOR), 0,
                ALU_NOR, SEL_LOGIC, 32'h0404_0404, 32'h0505_0505, 5'd6, 1'b1, 1'b0);
        add_row(r_type(5'd7, 5'd8, 5'd9, FN_ADDU), 0,
                ALU_ADDU, SEL_ARITH, 32'h0707_0707, 32'h0808_0808, 5'd9, 1'b1, 1'b0);
        add_row(r_type(5'd10, 5'd11, 5'd12, FN_SUB), 2,
                ALU_SUB, SEL_ARITH, 32'h0A0A_0A0A, 32'h0B0B_0B0B, 5'd12, 1'b1, 1'b0);
        add_row(r_type(5'd13, 5'd14, 5'd15, FN_SLT), 0,
                ALU_SLT, SEL_ARITH, 32'h0D0D_0D0D, 32'h0E0E_0E0E, 5'd15, 1'b1, 1'b0);
        add_row(r_type(5'd16, 5'd17, 5'd18, FN_SRAV), 1,
                ALU_SRA, SEL_SHIFT, 32'h1010_1010, 32'h1111_1111, 5'd18, 1'b1, 1'b0);
        // immediates land in reg2 and write rt
        set_reads(1'b1, 1'b0);
        add_row(i_type(OPC_ORI, 5'd2, 5'd4, 16'h8001), 0,
                ALU_OR, SEL_LOGIC, 32'h0202_0202, 32'h0000_8001, 5'd4, 1'b1, 1'b0);
        add_row(i_type(OPC_XORI, 5'd5, 5'd6, 16'h8001), 0,
                ALU_XOR, SEL_LOGIC, 32'h0505_0505, 32'h0000_8001, 5'd6, 1'b1, 1'b0);
        add_row(i_type(OPC_ADDI, 5'd7, 5'd8, 16'h8001), 0,
                ALU_ADDI, SEL_ARITH, 32'h0707_0707, 32'hFFFF_8001, 5'd8, 1'b1, 1'b0);
        add_row(i_type(OPC_SLTIU, 5'd9, 5'd10, 16'h8001), 3,
                ALU_SLTU, SEL_ARITH, 32'h0909_0909, 32'hFFFF_8001, 5'd10, 1'b1, 1'b0);
        add_row(i_type(OPC_LUI, 5'd0, 5'd11, 16'h1234), 0,
                ALU_OR, SEL_LOGIC, 32'h0000_0000, 32'h1234_0000, 5'd11, 1'b1, 1'b0);
        // shift amount comes through reg1
        set_reads(1'b0, 1'b1);
        add_row(shift_type(5'd19, 5'd20, 5'd5, FN_SLL), 0,
                ALU_SLL, SEL_SHIFT, 32'h0000_0005, 32'h1313_1313, 5'd20, 1'b1, 1'b0);
        add_row(shift_type(5'd22, 5'd21, 5'd31, FN_SRL), 0,
                ALU_SRL, SEL_SHIFT, 32'h0000_001F, 32'h1616_1616, 5'd21, 1'b1, 1'b0);
        add_row(shift_type(5'd24, 5'd23, 5'd1, FN_SRA), 1,
                ALU_SRA, SEL_SHIFT, 32'h0000_0001, 32'h1818_1818, 5'd23, 1'b1, 1'b0);
        set_reads(1'b1, 1'b1);
        set_bypass(1'b1, 5'd1, 32'hEEEE_0001, 1'b1, 5'd1, 32'hAAAA_0001);
        add_row(r_type(5'd1, 5'd2, 5'd3, FN_OR), 0,
                ALU_OR, SEL_LOGIC, 32'hEEEE_0001, 32'h0202_0202, 5'd3, 1'b1, 1'b0);
        set_bypass(1'b1, 5'd9, 32'hEEEE_0009, 1'b1, 5'd5, 32'hAAAA_0005);
        add_row(r_type(5'd5, 5'd6, 5'd7, FN_ADDU), 0,
                ALU_ADDU, SEL_ARITH, 32'hAAAA_0005, 32'h0606_0606, 5'd7, 1'b1, 1'b0);
        // execute targets rs but does not write
        set_bypass(1'b0, 5'd3, 32'hEEEE_0003, 1'b1, 5'd9, 32'hAAAA_0009);
        add_row(r_type(5'd3, 5'd4, 5'd5, FN_SUB), 2,
                ALU_SUB, SEL_ARITH, 32'h0303_0303, 32'h0404_0404, 5'd5, 1'b1, 1'b0);
        set_bypass(1'b1, 5'd2, 32'hEEEE_0002, 1'b1, 5'd2, 32'hAAAA_0002);
        add_row(r_type(5'd1, 5'd2, 5'd3, FN_AND), 0,
                ALU_AND, SEL_LOGIC, 32'h0101_0101, 32'hEEEE_0002, 5'd3, 1'b1, 1'b0);
        set_reads(1'b0, 1'b0);
        set_bypass(1'b1, 5'd1, 32'hEEEE_0001, 1'b1, 5'd2, 32'hAAAA_0002);
        add_row(i_type(6'h3F, 5'd1, 5'd2, 16'h1234), 0,
                ALU_NOP, SEL_NOP, 32'd0, 32'd0, 5'd0, 1'b0, 1'b1);
        set_bypass(1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
        add_row(r_type(5'd1, 5'd2, 5'd3, 6'h0F), 0,
                ALU_NOP, SEL_NOP, 32'd0, 32'd0, 5'd0, 1'b0, 1'b1);
        // OR with shamt 3
        add_row(r_type(5'd1, 5'd2, 5'd3, FN_OR) | 32'h0000_00C0, 0,
                ALU_NOP, SEL_NOP, 32'd0, 32'd0, 5'd0, 1'b0, 1'b1);
    endtask

    task automatic apply_row(input row_t r);
        inst_i       = r.inst;
        ex_wreg_i    = r.exw;
        ex_wd_i      = r.exd;
        ex_wdata_i   = r.exdata;
        mem_wreg_i   = r.memw;
        mem_wd_i     = r.memd;
        mem_wdata_i  = r.memdata;
        cur          = r;
        inst_valid_i = 1'b1;
        exp_push     = 1'b1;
    endtask

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout after %0d ns with %0d results outstanding", watchdog_ns, pending);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int n;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        ex_wreg_i    = 1'b0;
        ex_wd_i      = '0;
        ex_wdata_i   = '0;
        mem_wreg_i   = 1'b0;
        mem_wd_i     = '0;
        mem_wdata_i  = '0;
        exp_push     = 1'b0;
        final_check  = 1'b0;
        cur          = '0;
        build_table();
        watchdog_ns = (RESET_CYCLES + rows.size() + total_gap + 20) * 2 * CLK_HALF;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n_i = 1'b1;
        @(posedge clk);
        #2;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(posedge clk);
            #2;
            inst_valid_i = 1'b0;
            exp_push     = 1'b0;
            repeat (rows[i].gap) begin
                @(posedge clk);
                #2;
            end
        end
        // let the last results drain
        for (n = 0; n < 8 && pending != 0; n++) begin
            @(posedge clk);
        end
        #2 final_check = 1'b1;
        @(posedge clk);
        #2;
        $display("errors: %0d value, %0d sequence", value_errors, seq_errors);
        if (value_errors == 0 && seq_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
rtl/decode_pkg.sv
rtl/decode_if.sv
rtl/instr_decoder.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
test/decode_checker.sv
test/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary -f decode_stage.f --top-module decode_stage_tb -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vdecode_stage_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
